/* source/proc_consts.svh */
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// register file and gpio word width
`define PROC_WORD_W 8

// instruction word width
`define PROC_INSTR_W 16

// instruction memory address bits, 64 words
`define PROC_IMEM_AW 6
`define PROC_IMEM_DEPTH (1 << `PROC_IMEM_AW)

// wake timer width
`define PROC_TIMER_W 16

// number of general registers
`define PROC_NREGS 4

`endif

/* source/proc_pkg.sv */
`include "proc_consts.svh"

package proc_pkg;

  // --------------------
  // word types
  // --------------------
  typedef logic [`PROC_WORD_W-1:0] word_t;
  typedef logic [`PROC_INSTR_W-1:0] instr_t;
  typedef logic [`PROC_IMEM_AW-1:0] imem_addr_t;

  // opcode field, instr[15:12]
  // rd in 11:10, rs in 9:8, immediate in 7:0
  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_ldi   = 4'd1,
    op_add   = 4'd2,
    op_addi  = 4'd3,
    op_out   = 4'd4,
    op_oe    = 4'd5,
    op_in    = 4'd6,
    op_msk   = 4'd7,
    op_tmr   = 4'd8,
    op_jmp   = 4'd9,
    op_bnz   = 4'd10,
    op_sleep = 4'd11
  } opcode_t;

  // core sequencing, one instruction in flight
  typedef enum logic {st_fetch, st_exec} core_state_t;

endpackage

/* source/mem_if.sv */
`timescale 1ns/100ps

// single memory port, synchronous read
// rdata valid one clock after en with we low
interface mem_if import proc_pkg::*; ();

  logic       en;
  logic       we;
  imem_addr_t addr;
  instr_t     wdata;
  instr_t     rdata;

  // requester side
  modport client (
    output en, we, addr, wdata,
    input  rdata
  );

  // array side
  modport memory (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

/* source/core_mon_if.sv */
`timescale 1ns/100ps

// core status seen by the break unit and the top level
interface core_mon_if import proc_pkg::*; ();

  // pc and instr of the instruction last executed
  imem_addr_t pc;
  instr_t     instr;
  // one pulse per instruction, in execute
  logic       retire;
  // level, high from op_sleep until wakeup
  logic       sleep;

  modport core (output pc, instr, retire, sleep);

  modport monitor (input pc, instr, retire, sleep);

endinterface

/* source/prog_mem.sv */
`timescale 1ns/100ps
`include "proc_consts.svh"

module prog_mem import proc_pkg::*; (
  input logic   clk,
  mem_if.memory port_a,
  mem_if.memory port_b
);

  instr_t mem_array [`PROC_IMEM_DEPTH];

  // --------------------
  // write path
  // --------------------
  // both ports in one process, host port last so it wins a collision
  always_ff @(posedge clk) begin
    if (port_a.en && port_a.we) begin
      mem_array[port_a.addr] <= port_a.wdata;
    end
    if (port_b.en && port_b.we) begin
      mem_array[port_b.addr] <= port_b.wdata;
    end
  end

  // --------------------
  // read path
  // --------------------
  // registered read, holds while en is low
  always_ff @(posedge clk) begin
    if (port_a.en) begin
      port_a.rdata <= mem_array[port_a.addr];
    end
    if (port_b.en) begin
      port_b.rdata <= mem_array[port_b.addr];
    end
  end

endmodule

/* source/host_access.sv */
`timescale 1ns/100ps

module host_access import proc_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   host_load,
  input  logic   host_we,
  input  logic   host_re,
  input  instr_t host_wdata,
  output instr_t host_rdata,
  output logic   host_rvalid,
  mem_if.client  mem
);

  imem_addr_t addr;
  imem_addr_t base;

  // load restarts the stream at word 0, even for an access in the same cycle
  assign base = host_load ? '0 : addr;

  // one memory access per strobe
  assign mem.en    = host_we | host_re;
  assign mem.we    = host_we;
  assign mem.addr  = base;
  assign mem.wdata = host_wdata;

  // read data comes straight off the port, qualified by host_rvalid
  assign host_rdata = mem.rdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr        <= '0;
      host_rvalid <= 1'b0;
    end else begin
      // pairs with the one-cycle read latency
      host_rvalid <= host_re;
      // auto increment after every access
      if (mem.en) begin
        addr <= base + 1'b1;
      end else if (host_load) begin
        addr <= '0;
      end
    end
  end

endmodule

/* source/core_exec.sv */
`timescale 1ns/100ps
`include "proc_consts.svh"

module core_exec import proc_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       wakeup,
  input  word_t      gin_sync,
  output logic       out_we,
  output logic       oe_we,
  output logic       msk_we,
  output logic       tmr_we,
  output word_t      out_data,
  output word_t      tmr_data,
  mem_if.client      imem,
  core_mon_if.core   mon
);

  core_state_t state;
  imem_addr_t  pc;
  imem_addr_t  exec_pc;
  imem_addr_t  next_pc;
  instr_t      instr_q;
  logic        sleep_q;
  logic        exec;
  word_t [`PROC_NREGS-1:0] regs;

  // decode fields
  instr_t     instr;
  opcode_t    opcode;
  logic [1:0] rd_idx;
  logic [1:0] rs_idx;
  word_t      imm;
  word_t      rd_val;
  word_t      rs_val;

  // --------------------
  // decode
  // --------------------
  // rdata is the fetched word for the whole execute cycle
  assign instr  = imem.rdata;
  assign opcode = opcode_t'(instr[15:12]);
  assign rd_idx = instr[11:10];
  assign rs_idx = instr[9:8];
  assign imm    = instr[`PROC_WORD_W-1:0];
  assign rd_val = regs[rd_idx];
  assign rs_val = regs[rs_idx];
  assign exec   = (state == st_exec);

  // fetch port, read only
  assign imem.en    = (state == st_fetch);
  assign imem.we    = 1'b0;
  assign imem.addr  = pc;
  assign imem.wdata = '0;

  // branch target wraps to 64 words
  always_comb begin
    next_pc = pc + 1'b1;
    if (opcode == op_jmp || (opcode == op_bnz && rd_val != '0)) begin
      next_pc = imm[`PROC_IMEM_AW-1:0];
    end
  end

  // --------------------
  // side strobes
  // --------------------
  // only during execute, so a frozen fetch never repeats one
  always_comb begin
    out_we   = 1'b0;
    oe_we    = 1'b0;
    msk_we   = 1'b0;
    tmr_we   = 1'b0;
    out_data = rd_val;
    tmr_data = rd_val;
    if (exec) begin
      case (opcode)
        op_out: out_we = 1'b1;
        op_oe: begin
          oe_we    = 1'b1;
          out_data = imm;
        end
        // mask shares the timer data lines
        op_msk: begin
          msk_we   = 1'b1;
          tmr_data = imm;
        end
        op_tmr: tmr_we = 1'b1;
        default: ;
      endcase
    end
  end

  // --------------------
  // fsm and register file
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= st_fetch;
      pc      <= '0;
      exec_pc <= '0;
      instr_q <= '0;
      sleep_q <= 1'b0;
      regs    <= '0;
    end else begin
      // wakeup ends sleep on the first running edge
      if (sleep_q && wakeup) begin
        sleep_q <= 1'b0;
      end
      case (state)
        st_fetch: begin
          // hold in fetch while asleep, even under a forced clock
          if (!sleep_q || wakeup) begin
            state   <= st_exec;
            exec_pc <= pc;
          end
        end
        st_exec: begin
          state   <= st_fetch;
          instr_q <= instr;
          pc      <= next_pc;
          case (opcode)
            op_ldi:   regs[rd_idx] <= imm;
            op_add:   regs[rd_idx] <= rd_val + rs_val;
            op_addi:  regs[rd_idx] <= rd_val + imm;
            op_in:    regs[rd_idx] <= gin_sync;
            op_sleep: sleep_q <= 1'b1;
            default: ;
          endcase
        end
        default: state <= st_fetch;
      endcase
    end
  end

  // --------------------
  // monitor
  // --------------------
  // instr stays valid after execute through the saved copy
  assign mon.pc     = exec_pc;
  assign mon.instr  = exec ? instr : instr_q;
  assign mon.retire = exec;
  assign mon.sleep  = sleep_q;

endmodule

/* source/wake_ctrl.sv */
`timescale 1ns/100ps
`include "proc_consts.svh"

module wake_ctrl import proc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  doorbell,
  input  word_t gin_rise,
  input  logic  msk_we,
  input  logic  tmr_we,
  input  word_t tmr_data,
  input  logic  sleep,
  output logic  wakeup
);

  word_t                   mask;
  logic [`PROC_TIMER_W-1:0] timer;
  logic                    timer_hit;
  logic                    pend_db;
  logic                    pend_tmr;
  logic                    pend_gpio;
  logic                    fire;

  // timer steps from 1 to 0 this cycle, a reload takes priority
  assign timer_hit = (timer == `PROC_TIMER_W'(1)) && !tmr_we;

  // one wakeup per sleep, pending flags cleared with it
  assign fire = sleep && !wakeup && (pend_db || pend_tmr || pend_gpio);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mask      <= '0;
      timer     <= '0;
      pend_db   <= 1'b0;
      pend_tmr  <= 1'b0;
      pend_gpio <= 1'b0;
      wakeup    <= 1'b0;
    end else begin
      wakeup <= fire;

      if (msk_we) begin
        mask <= tmr_data;
      end

      // --------------------
      // timer, loaded with rd times 4
      // --------------------
      if (tmr_we) begin
        timer <= {{(`PROC_TIMER_W-`PROC_WORD_W-2){1'b0}}, tmr_data, 2'b00};
      end else if (timer != '0) begin
        timer <= timer - 1'b1;
      end

      // new sources survive the clearing edge
      pend_db   <= (pend_db & ~fire) | doorbell;
      pend_tmr  <= (pend_tmr & ~fire) | timer_hit;
      pend_gpio <= (pend_gpio & ~fire) | (|(gin_rise & mask));
    end
  end

endmodule

/* source/break_unit.sv */
`timescale 1ns/100ps

module break_unit import proc_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       brk_en,
  input  imem_addr_t brk_addr,
  input  logic       resume,
  core_mon_if.monitor mon,
  output logic       brk
);

  logic armed;
  logic pc_match;
  logic hit;

  assign pc_match = (mon.pc == brk_addr);

  // retire may sit high for many clk while the core is frozen
  assign hit = mon.retire && brk_en && armed && pc_match;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      brk   <= 1'b0;
      armed <= 1'b1;
    end else begin
      // --------------------
      // break level
      // --------------------
      if (hit) begin
        brk <= 1'b1;
      end else if (resume) begin
        brk <= 1'b0;
      end

      // disarm on trigger, re-arm once the core has moved on
      if (hit) begin
        armed <= 1'b0;
      end else if (!armed && !pc_match) begin
        armed <= 1'b1;
      end
    end
  end

endmodule

/* source/power_ctrl.sv */
`timescale 1ns/100ps

module power_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic en,
  input  logic clk_force_on,
  input  logic clk_force_off,
  input  logic wakeup,
  input  logic brk,
  input  logic sleep,
  output logic proc_clk,
  output logic core_reset,
  output logic sleep_status,
  output logic break_status
);

  logic stop_clk;
  logic clk_en;

  // stopped on break, or asleep with no wakeup pending
  assign stop_clk = brk | (sleep & ~wakeup);

  // --------------------
  // clock gate
  // --------------------
  // transparent while clk is low, so the enable is stable over the high phase
  always_latch begin
    if (!clk) begin
      clk_en = (~stop_clk & ~clk_force_off) | clk_force_on;
    end
  end

  assign proc_clk = clk & clk_en;

  // core held in reset while disabled
  assign core_reset = reset | ~en;

  // --------------------
  // status
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sleep_status <= 1'b0;
      break_status <= 1'b0;
    end else begin
      sleep_status <= sleep;
      break_status <= brk;
    end
  end

endmodule

/* source/gpio_port.sv */
`timescale 1ns/100ps

module gpio_port import proc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t gin,
  input  logic  out_we,
  input  logic  oe_we,
  input  word_t out_data,
  output word_t gin_sync,
  output word_t gin_rise,
  output word_t gout,
  output word_t goe
);

  word_t gin_meta;
  word_t gin_last;

  // rising edge per bit, after the second stage
  assign gin_rise = gin_sync & ~gin_last;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gin_meta <= '0;
      gin_sync <= '0;
      gin_last <= '0;
      gout     <= '0;
      goe      <= '0;
    end else begin
      // two flop synchroniser
      gin_meta <= gin;
      gin_sync <= gin_meta;
      gin_last <= gin_sync;
      // output and enable share the data word
      if (out_we) begin
        gout <= out_data;
      end
      if (oe_we) begin
        goe <= out_data;
      end
    end
  end

endmodule

/* source/proc_top.sv */
`timescale 1ns/100ps

module proc_top import proc_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       en,
  input  logic       clk_force_on,
  input  logic       clk_force_off,
  input  logic       doorbell,
  input  word_t      gin,
  input  logic       host_load,
  input  logic       host_we,
  input  logic       host_re,
  input  instr_t     host_wdata,
  input  logic       brk_en,
  input  imem_addr_t brk_addr,
  input  logic       resume,
  output instr_t     host_rdata,
  output logic       host_rvalid,
  output word_t      gout,
  output word_t      goe,
  output logic       sleep_status,
  output logic       break_status,
  output imem_addr_t mon_pc,
  output instr_t     mon_instr
);

  logic  proc_clk;
  logic  core_reset;
  logic  wakeup;
  logic  brk;
  logic  out_we;
  logic  oe_we;
  logic  msk_we;
  logic  tmr_we;
  word_t out_data;
  word_t tmr_data;
  word_t gin_sync;
  word_t gin_rise;

  mem_if      core_imem ();
  mem_if      host_imem ();
  core_mon_if core_mon ();

  assign mon_pc    = core_mon.pc;
  assign mon_instr = core_mon.instr;

  // --------------------
  // input side
  // --------------------
  host_access host_access_inst (
    .clk         (clk),
    .reset       (reset),
    .host_load   (host_load),
    .host_we     (host_we),
    .host_re     (host_re),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .mem         (host_imem.client)
  );

  // core on port a, host on port b, both on the free clock
  prog_mem prog_mem_inst (
    .clk    (clk),
    .port_a (core_imem.memory),
    .port_b (host_imem.memory)
  );

  // --------------------
  // core and its control
  // --------------------
  core_exec core_exec_inst (
    .clk      (proc_clk),
    .reset    (core_reset),
    .wakeup   (wakeup),
    .gin_sync (gin_sync),
    .out_we   (out_we),
    .oe_we    (oe_we),
    .msk_we   (msk_we),
    .tmr_we   (tmr_we),
    .out_data (out_data),
    .tmr_data (tmr_data),
    .imem     (core_imem.client),
    .mon      (core_mon.core)
  );

  power_ctrl power_ctrl_inst (
    .clk           (clk),
    .reset         (reset),
    .en            (en),
    .clk_force_on  (clk_force_on),
    .clk_force_off (clk_force_off),
    .wakeup        (wakeup),
    .brk           (brk),
    .sleep         (core_mon.sleep),
    .proc_clk      (proc_clk),
    .core_reset    (core_reset),
    .sleep_status  (sleep_status),
    .break_status  (break_status)
  );

  break_unit break_unit_inst (
    .clk      (clk),
    .reset    (reset),
    .brk_en   (brk_en),
    .brk_addr (brk_addr),
    .resume   (resume),
    .mon      (core_mon.monitor),
    .brk      (brk)
  );

  wake_ctrl wake_ctrl_inst (
    .clk      (clk),
    .reset    (reset),
    .doorbell (doorbell),
    .gin_rise (gin_rise),
    .msk_we   (msk_we),
    .tmr_we   (tmr_we),
    .tmr_data (tmr_data),
    .sleep    (core_mon.sleep),
    .wakeup   (wakeup)
  );

  // --------------------
  // output side
  // --------------------
  gpio_port gpio_port_inst (
    .clk      (clk),
    .reset    (reset),
    .gin      (gin),
    .out_we   (out_we),
    .oe_we    (oe_we),
    .out_data (out_data),
    .gin_sync (gin_sync),
    .gin_rise (gin_rise),
    .gout     (gout),
    .goe      (goe)
  );

endmodule

/* tests/tb_proc_top.sv */
`timescale 1ns/100ps
`include "proc_consts.svh"

module tb_proc_top import proc_pkg::*; ();

  // cycle budget per test, the watchdog gets their sum
  localparam int budget_load     = 1000;
  localparam int budget_arith    = 3000;
  localparam int budget_doorbell = 3000;
  localparam int budget_wake     = 5000;
  localparam int budget_break    = 5000;
  localparam int budget_disable  = 3000;
  localparam int watchdog_cycles = budget_load + budget_arith + budget_doorbell +
                                   budget_wake + budget_break + budget_disable;
  // bound for a single wait inside a test
  localparam int wait_bound = 300;

  logic       clk;
  logic       reset;
  logic       en;
  logic       clk_force_on;
  logic       clk_force_off;
  logic       doorbell;
  word_t      gin;
  logic       host_load;
  logic       host_we;
  logic       host_re;
  instr_t     host_wdata;
  logic       brk_en;
  imem_addr_t brk_addr;
  logic       resume;
  instr_t     host_rdata;
  logic       host_rvalid;
  word_t      gout;
  word_t      goe;
  logic       sleep_status;
  logic       break_status;
  imem_addr_t mon_pc;
  instr_t     mon_instr;

  // program image handed to the host loader
  instr_t prog_buf [`PROC_IMEM_DEPTH];
  int     errors;
  int     checks;
  int     seed_val;

  proc_top proc_top_inst (
    .clk           (clk),
    .reset         (reset),
    .en            (en),
    .clk_force_on  (clk_force_on),
    .clk_force_off (clk_force_off),
    .doorbell      (doorbell),
    .gin           (gin),
    .host_load     (host_load),
    .host_we       (host_we),
    .host_re       (host_re),
    .host_wdata    (host_wdata),
    .brk_en        (brk_en),
    .brk_addr      (brk_addr),
    .resume        (resume),
    .host_rdata    (host_rdata),
    .host_rvalid   (host_rvalid),
    .gout          (gout),
    .goe           (goe),
    .sleep_status  (sleep_status),
    .break_status  (break_status),
    .mon_pc        (mon_pc),
    .mon_instr     (mon_instr)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // --------------------
  // watchdog
  // --------------------
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Done: errors found");
    $finish;
  end

  // opcode in 15:12, rd 11:10, rs 9:8, immediate 7:0
  function automatic instr_t enc(input opcode_t op, input logic [1:0] rd,
                                 input logic [1:0] rs, input word_t imm);
    enc = {op, rd, rs, imm};
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_instr(input string name, input instr_t expected, input instr_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_pc(input string name, input imem_addr_t expected,
                          input imem_addr_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // --------------------
  // stimulus helpers
  // --------------------
  task automatic run_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // core held disabled after reset until a program is loaded
  task automatic reset_dut;
    @(posedge clk);
    reset         <= 1'b1;
    en            <= 1'b0;
    doorbell      <= 1'b0;
    gin           <= '0;
    host_load     <= 1'b0;
    host_we       <= 1'b0;
    host_re       <= 1'b0;
    host_wdata    <= '0;
    brk_en        <= 1'b0;
    brk_addr      <= '0;
    resume        <= 1'b0;
    clk_force_on  <= 1'b0;
    clk_force_off <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  endtask

  // pointer back to 0, then one word per cycle
  task automatic load_prog(input int n);
    int i;
    @(posedge clk);
    host_load <= 1'b1;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      host_load  <= 1'b0;
      host_we    <= 1'b1;
      host_wdata <= prog_buf[i];
    end
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  task automatic start_prog(input int n);
    reset_dut;
    load_prog(n);
    @(posedge clk);
    en <= 1'b1;
  endtask

  task automatic ring_doorbell;
    @(posedge clk);
    doorbell <= 1'b1;
    @(posedge clk);
    doorbell <= 1'b0;
  endtask

  // --------------------
  // bounded waits, sampled on the falling edge
  // --------------------
  task automatic wait_pc(input string name, input imem_addr_t addr, input int bound);
    int n;
    n = 0;
    @(negedge clk);
    while (mon_pc !== addr && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (mon_pc !== addr) begin
      errors++;
      $display("%s: pc did not reach %0d within %0d cycles", name, addr, bound);
    end
  endtask

  task automatic wait_gout(input string name, input word_t value, input int bound);
    int n;
    n = 0;
    @(negedge clk);
    while (gout !== value && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (gout !== value) begin
      errors++;
      $display("%s: gout did not become %h within %0d cycles", name, value, bound);
    end
  endtask

  task automatic wait_sleep(input string name, input logic level, input int bound);
    int n;
    n = 0;
    @(negedge clk);
    while (sleep_status !== level && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (sleep_status !== level) begin
      errors++;
      $display("%s: sleep status did not go to %b within %0d cycles", name, level, bound);
    end
  endtask

  task automatic wait_break(input string name, input logic level, input int bound);
    int n;
    n = 0;
    @(negedge clk);
    while (break_status !== level && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (break_status !== level) begin
      errors++;
      $display("%s: break status did not go to %b within %0d cycles", name, level, bound);
    end
  endtask

  // gout must stay put every cycle
  task automatic hold_gout(input string name, input word_t value, input int n);
    repeat (n) begin
      @(negedge clk);
      check_word(name, value, gout);
    end
  endtask

  // pc and gout both frozen
  task automatic hold_frozen(input string name, input imem_addr_t addr,
                             input word_t value, input int n);
    repeat (n) begin
      @(negedge clk);
      check_pc({name, " pc"}, addr, mon_pc);
      check_word({name, " gout"}, value, gout);
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_load_readback;
    instr_t sent [20];
    int     i;
    for (i = 0; i < 20; i++) begin
      sent[i]     = instr_t'($urandom);
      prog_buf[i] = sent[i];
    end
    load_prog(20);
    @(posedge clk);
    host_load <= 1'b1;
    @(posedge clk);
    host_load <= 1'b0;
    // one read at a time, rvalid exactly one cycle later
    for (i = 0; i < 20; i++) begin
      @(posedge clk);
      host_re <= 1'b1;
      @(negedge clk);
      check_bit("readback rvalid idle", 1'b0, host_rvalid);
      @(posedge clk);
      host_re <= 1'b0;
      @(negedge clk);
      check_bit("readback rvalid", 1'b1, host_rvalid);
      check_instr($sformatf("readback word %0d", i), sent[i], host_rdata);
    end
  endtask

  task automatic test_arith;
    word_t a;
    word_t b;
    word_t oe_val;
    word_t sum;
    word_t loop_sum;
    a      = word_t'($urandom);
    b      = word_t'($urandom);
    oe_val = word_t'($urandom);
    // wraps modulo 256 in the word type
    sum    = a + b;
    // five passes, each adding 7
    loop_sum = word_t'(5 * 7);
    prog_buf[0]  = enc(op_ldi, 2'd0, 2'd0, a);
    prog_buf[1]  = enc(op_ldi, 2'd1, 2'd0, b);
    prog_buf[2]  = enc(op_add, 2'd0, 2'd1, 8'h00);
    prog_buf[3]  = enc(op_oe, 2'd0, 2'd0, oe_val);
    prog_buf[4]  = enc(op_out, 2'd0, 2'd0, 8'h00);
    // countdown of 5 in r2, r3 accumulates per pass
    prog_buf[5]  = enc(op_ldi, 2'd2, 2'd0, 8'h05);
    prog_buf[6]  = enc(op_ldi, 2'd3, 2'd0, 8'h00);
    prog_buf[7]  = enc(op_addi, 2'd3, 2'd0, 8'h07);
    prog_buf[8]  = enc(op_addi, 2'd2, 2'd0, 8'hff);
    prog_buf[9]  = enc(op_bnz, 2'd2, 2'd0, 8'h07);
    prog_buf[10] = enc(op_out, 2'd3, 2'd0, 8'h00);
    prog_buf[11] = enc(op_jmp, 2'd0, 2'd0, 8'h0b);
    start_prog(12);
    wait_pc("arith out", 6'd5, wait_bound);
    check_word("arith sum", sum, gout);
    check_word("arith oe", oe_val, goe);
    wait_pc("arith loop exit", 6'd10, wait_bound);
    check_word("arith during loop", sum, gout);
    wait_pc("arith halt", 6'd11, wait_bound);
    check_word("arith loop result", loop_sum, gout);
  endtask

  task automatic test_doorbell;
    prog_buf[0] = enc(op_ldi, 2'd0, 2'd0, 8'h01);
    prog_buf[1] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[2] = enc(op_sleep, 2'd0, 2'd0, 8'h00);
    prog_buf[3] = enc(op_ldi, 2'd0, 2'd0, 8'h02);
    prog_buf[4] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[5] = enc(op_jmp, 2'd0, 2'd0, 8'h05);
    start_prog(6);
    wait_sleep("doorbell sleep", 1'b1, wait_bound);
    hold_gout("doorbell asleep", 8'h01, 50);
    check_bit("doorbell still asleep", 1'b1, sleep_status);
    ring_doorbell;
    wait_gout("doorbell wake", 8'h02, wait_bound);
    check_bit("doorbell sleep cleared", 1'b0, sleep_status);
  endtask

  task automatic test_timer_gpio;
    word_t gin_val;
    // timer loaded with 10 times 4
    prog_buf[0] = enc(op_ldi, 2'd0, 2'd0, 8'd10);
    prog_buf[1] = enc(op_ldi, 2'd1, 2'd0, 8'h11);
    prog_buf[2] = enc(op_out, 2'd1, 2'd0, 8'h00);
    prog_buf[3] = enc(op_tmr, 2'd0, 2'd0, 8'h00);
    prog_buf[4] = enc(op_sleep, 2'd0, 2'd0, 8'h00);
    prog_buf[5] = enc(op_ldi, 2'd1, 2'd0, 8'h22);
    prog_buf[6] = enc(op_out, 2'd1, 2'd0, 8'h00);
    prog_buf[7] = enc(op_jmp, 2'd0, 2'd0, 8'h07);
    start_prog(8);
    wait_pc("timer load", 6'd4, wait_bound);
    hold_gout("timer early", 8'h11, 38);
    check_bit("timer asleep", 1'b1, sleep_status);
    wait_gout("timer wake", 8'h22, 40);

    // gpio edge on mask bit 3
    gin_val = (word_t'($urandom) & 8'hf7) | 8'h08;
    prog_buf[0] = enc(op_msk, 2'd0, 2'd0, 8'h08);
    prog_buf[1] = enc(op_ldi, 2'd1, 2'd0, 8'h33);
    prog_buf[2] = enc(op_out, 2'd1, 2'd0, 8'h00);
    prog_buf[3] = enc(op_sleep, 2'd0, 2'd0, 8'h00);
    prog_buf[4] = enc(op_in, 2'd2, 2'd0, 8'h00);
    prog_buf[5] = enc(op_out, 2'd2, 2'd0, 8'h00);
    prog_buf[6] = enc(op_jmp, 2'd0, 2'd0, 8'h06);
    start_prog(7);
    wait_sleep("gpio sleep", 1'b1, wait_bound);
    hold_gout("gpio asleep", 8'h33, 10);
    @(posedge clk);
    gin <= gin_val;
    wait_gout("gpio wake", gin_val, wait_bound);
  endtask

  task automatic test_break_force;
    imem_addr_t frozen_pc;
    word_t      frozen_out;
    prog_buf[0] = enc(op_ldi, 2'd0, 2'd0, 8'h01);
    prog_buf[1] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[2] = enc(op_ldi, 2'd0, 2'd0, 8'h02);
    prog_buf[3] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[4] = enc(op_ldi, 2'd0, 2'd0, 8'h03);
    prog_buf[5] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[6] = enc(op_jmp, 2'd0, 2'd0, 8'h06);
    start_prog(7);
    @(posedge clk);
    brk_en   <= 1'b1;
    brk_addr <= 6'd3;
    // the out at the break address still completes
    wait_break("break hit", 1'b1, wait_bound);
    // monitor keeps the instruction that hit
    check_instr("break instr", prog_buf[3], mon_instr);
    hold_frozen("break frozen", 6'd3, 8'h02, 50);
    @(posedge clk);
    resume <= 1'b1;
    @(posedge clk);
    resume <= 1'b0;
    wait_gout("break resume", 8'h03, wait_bound);
    wait_break("break cleared", 1'b0, wait_bound);

    // free running counter, then clock forced off
    prog_buf[0] = enc(op_addi, 2'd0, 2'd0, 8'h01);
    prog_buf[1] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[2] = enc(op_jmp, 2'd0, 2'd0, 8'h00);
    start_prog(3);
    run_cycles(20);
    @(posedge clk);
    clk_force_off <= 1'b1;
    run_cycles(3);
    frozen_pc  = mon_pc;
    frozen_out = gout;
    hold_frozen("force off", frozen_pc, frozen_out, 30);
    @(posedge clk);
    clk_force_off <= 1'b0;
    wait_gout("force off release", frozen_out + 8'd1, wait_bound);

    // forced clock while asleep
    prog_buf[0] = enc(op_ldi, 2'd0, 2'd0, 8'h44);
    prog_buf[1] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[2] = enc(op_sleep, 2'd0, 2'd0, 8'h00);
    prog_buf[3] = enc(op_ldi, 2'd0, 2'd0, 8'h55);
    prog_buf[4] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[5] = enc(op_jmp, 2'd0, 2'd0, 8'h05);
    start_prog(6);
    wait_sleep("force on sleep", 1'b1, wait_bound);
    @(posedge clk);
    clk_force_on <= 1'b1;
    run_cycles(2);
    hold_frozen("force on", 6'd2, 8'h44, 30);
    check_bit("force on still asleep", 1'b1, sleep_status);
    @(posedge clk);
    clk_force_on <= 1'b0;
    ring_doorbell;
    wait_gout("force on wake", 8'h55, wait_bound);
  endtask

  task automatic test_disable;
    prog_buf[0] = enc(op_ldi, 2'd0, 2'd0, 8'h5a);
    prog_buf[1] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[2] = enc(op_ldi, 2'd0, 2'd0, 8'h6b);
    prog_buf[3] = enc(op_out, 2'd0, 2'd0, 8'h00);
    prog_buf[4] = enc(op_jmp, 2'd0, 2'd0, 8'h04);
    start_prog(5);
    wait_pc("disable first run", 6'd4, wait_bound);
    check_word("disable first out", 8'h6b, gout);
    @(posedge clk);
    en <= 1'b0;
    run_cycles(2);
    check_pc("disable pc", 6'd0, mon_pc);
    // gpio is on the system reset, so the last output stays
    check_word("disable gout kept", 8'h6b, gout);
    @(posedge clk);
    en <= 1'b1;
    wait_gout("disable rerun first out", 8'h5a, wait_bound);
    wait_pc("disable rerun", 6'd4, wait_bound);
    check_word("disable rerun last out", 8'h6b, gout);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    en            = 1'b0;
    clk_force_on  = 1'b0;
    clk_force_off = 1'b0;
    doorbell      = 1'b0;
    gin           = '0;
    host_load     = 1'b0;
    host_we       = 1'b0;
    host_re       = 1'b0;
    host_wdata    = '0;
    brk_en        = 1'b0;
    brk_addr      = '0;
    resume        = 1'b0;
    errors        = 0;
    checks        = 0;
    seed_val      = $urandom(5);

    reset_dut;
    test_load_readback;
    test_arith;
    test_doorbell;
    test_timer_gpio;
    test_break_force;
    test_disable;
    run_cycles(5);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+source
source/proc_pkg.sv
source/mem_if.sv
source/core_mon_if.sv
source/prog_mem.sv
source/host_access.sv
source/core_exec.sv
source/wake_ctrl.sv
source/break_unit.sv
source/power_ctrl.sv
source/gpio_port.sv
source/proc_top.sv
tests/tb_proc_top.sv
